//--- verilog/yuvPkg.sv
// Shared types and constants for the YUV 4:2:2 to RGB pipeline
// Pixel structs, window FSM states, filter and colour matrix constants
// Saturating clip to one 8-bit component
package yuvPkg;

    localparam int pixelWidth = 8;
    localparam int pixelMax = (1 << pixelWidth) - 1;

    // Chroma interpolation filter
    localparam int filterLength = 10;
    // Tap holding the even chroma of the current pair
    localparam int centreTap = 4;
    localparam int filterTaps [filterLength] = '{
        36, -98, -233, 528, 1815, 1815, 528, -233, -98, 36
    };
    localparam int filterShift = 12;
    localparam int filterRound = 2048;

    // Fixed-point colour matrix, scaled by 2^15
    localparam int lumaGain = 38142;
    localparam int rFromV = 52298;
    localparam int gFromU = 12845;
    localparam int gFromV = 26640;
    localparam int bFromU = 66093;
    localparam int matrixRound = 16384;
    localparam int matrixShift = 15;
    localparam int lumaOffset = 16;
    localparam int chromaOffset = 128;

    // One input beat, two luma samples sharing one chroma pair
    typedef struct packed {
        logic [pixelWidth-1:0] yEven;
        logic [pixelWidth-1:0] yOdd;
        logic [pixelWidth-1:0] u;
        logic [pixelWidth-1:0] v;
    } yuvPairT;

    // Even chroma is tap centreTap of each window
    typedef struct packed {
        logic [pixelWidth-1:0]                   yEven;
        logic [pixelWidth-1:0]                   yOdd;
        logic [filterLength-1:0][pixelWidth-1:0] uTaps;
        logic [filterLength-1:0][pixelWidth-1:0] vTaps;
    } windowT;

    typedef struct packed {
        logic [pixelWidth-1:0] yEven;
        logic [pixelWidth-1:0] yOdd;
        logic [pixelWidth-1:0] uEven;
        logic [pixelWidth-1:0] vEven;
        logic [pixelWidth-1:0] uOdd;
        logic [pixelWidth-1:0] vOdd;
    } yuvFullT;

    typedef struct packed {
        logic [pixelWidth-1:0] rEven;
        logic [pixelWidth-1:0] gEven;
        logic [pixelWidth-1:0] bEven;
        logic [pixelWidth-1:0] rOdd;
        logic [pixelWidth-1:0] gOdd;
        logic [pixelWidth-1:0] bOdd;
    } rgbPairT;

    typedef enum logic [1:0] {
        winFill,
        winStream,
        winDrain
    } windowStateT;

    function automatic logic [pixelWidth-1:0] clipPixel(input int value);
        logic [pixelWidth-1:0] result;
        if (value < 0) begin
            result = '0;
        end else if (value > pixelMax) begin
            result = '1;
        end else begin
            result = pixelWidth'(value);
        end
        return result;
    endfunction

endpackage

//--- verilog/chromaWindow.sv
// Line-aware sliding window of ten U and ten V samples
// Luma delay to align with the window centre
// Fill, stream and drain FSM with a registered valid/ready output
`timescale 1ns/1ps

module chromaWindow #(
    parameter int LineWidth = 160
) (
    input  logic            Clock,
    input  logic            Resetn,
    input  logic            inValid,
    input  yuvPkg::yuvPairT inPair,
    output logic            inReady,
    output logic            winValid,
    output yuvPkg::windowT  winData,
    input  logic            winReady
);
    import yuvPkg::*;

    localparam int countWidth = $clog2(LineWidth);
    localparam int lumaDepth = filterLength - centreTap;
    localparam logic [countWidth-1:0] lastIndex = countWidth'(LineWidth - 1);
    // Input that completes the first window of a line
    localparam logic [countWidth-1:0] primeIndex = countWidth'(lumaDepth - 1);

    windowStateT state;
    logic [countWidth-1:0] inCount;
    logic [countWidth-1:0] outCount;

    // Oldest sample at tap 0, newest at the top tap
    logic [filterLength-1:0][pixelWidth-1:0] uTaps;
    logic [filterLength-1:0][pixelWidth-1:0] vTaps;
    logic [filterLength-1:0][pixelWidth-1:0] uNext;
    logic [filterLength-1:0][pixelWidth-1:0] vNext;
    logic [lumaDepth-1:0][pixelWidth-1:0]    yEvenDelay;
    logic [lumaDepth-1:0][pixelWidth-1:0]    yOddDelay;
    logic [lumaDepth-1:0][pixelWidth-1:0]    yEvenNext;
    logic [lumaDepth-1:0][pixelWidth-1:0]    yOddNext;

    logic [pixelWidth-1:0] newU;
    logic [pixelWidth-1:0] newV;
    logic [pixelWidth-1:0] newYEven;
    logic [pixelWidth-1:0] newYOdd;

    logic advance;
    logic accept;
    logic drainStep;
    logic shiftEn;
    logic emit;
    logic lineStart;
    logic lastIn;
    logic lastOut;

    always_comb begin
        advance   = !winValid || winReady;
        inReady   = (state != winDrain) && advance;
        accept    = inValid && inReady;
        drainStep = (state == winDrain) && advance;
        shiftEn   = accept || drainStep;
        lineStart = (state == winFill) && (inCount == '0);
        lastIn    = (inCount == lastIndex);
        lastOut   = (outCount == lastIndex);
        // Every stream input and every drain step completes one window
        emit = drainStep ||
               (accept && (state == winStream ||
                           (state == winFill && inCount == primeIndex)));
    end

    always_comb begin
        if (state == winDrain) begin
            // Right edge replicates the last sample of the line
            newU     = uTaps[filterLength-1];
            newV     = vTaps[filterLength-1];
            newYEven = yEvenDelay[lumaDepth-1];
            newYOdd  = yOddDelay[lumaDepth-1];
        end else begin
            newU     = inPair.u;
            newV     = inPair.v;
            newYEven = inPair.yEven;
            newYOdd  = inPair.yOdd;
        end
        uNext     = {newU, uTaps[filterLength-1:1]};
        vNext     = {newV, vTaps[filterLength-1:1]};
        yEvenNext = {newYEven, yEvenDelay[lumaDepth-1:1]};
        yOddNext  = {newYOdd, yOddDelay[lumaDepth-1:1]};
        if (lineStart) begin
            // Left edge, the first sample fills the older taps
            uNext = {filterLength{newU}};
            vNext = {filterLength{newV}};
        end
    end

    always_ff @(posedge Clock or negedge Resetn) begin
        if (!Resetn) begin
            state    <= winFill;
            inCount  <= '0;
            outCount <= '0;
            winValid <= 1'b0;
        end else begin
            if (advance) begin
                winValid <= emit;
            end
            if (accept) begin
                inCount <= lastIn ? '0 : inCount + 1'b1;
            end
            if (emit) begin
                outCount <= lastOut ? '0 : outCount + 1'b1;
            end
            case (state)
                winFill: begin
                    if (accept && inCount == primeIndex) begin
                        state <= lastIn ? winDrain : winStream;
                    end
                end
                winStream: begin
                    if (accept && lastIn) begin
                        state <= winDrain;
                    end
                end
                winDrain: begin
                    if (drainStep && lastOut) begin
                        state <= winFill;
                    end
                end
                default: state <= winFill;
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (shiftEn) begin
            uTaps      <= uNext;
            vTaps      <= vNext;
            yEvenDelay <= yEvenNext;
            yOddDelay  <= yOddNext;
        end
        if (emit) begin
            winData.yEven <= yEvenNext[0];
            winData.yOdd  <= yOddNext[0];
            winData.uTaps <= uNext;
            winData.vTaps <= vNext;
        end
    end

endmodule

//--- verilog/chromaFilter.sv
// Registered 10-tap interpolation of the odd U and V samples
// Rounds, scales and clips each result to 8 bits
`timescale 1ns/1ps

module chromaFilter (
    input  logic            Clock,
    input  logic            Resetn,
    input  logic            winValid,
    input  yuvPkg::windowT  winData,
    output logic            winReady,
    output logic            fullValid,
    output yuvPkg::yuvFullT fullData,
    input  logic            fullReady
);
    import yuvPkg::*;

    logic advance;
    int   accU;
    int   accV;

    always_comb begin
        advance  = !fullValid || fullReady;
        winReady = advance;
    end

    // Symmetric taps centred between the current and next pair
    always_comb begin
        accU = filterRound;
        accV = filterRound;
        for (int i = 0; i < filterLength; i++) begin
            accU += filterTaps[i] * int'(winData.uTaps[i]);
            accV += filterTaps[i] * int'(winData.vTaps[i]);
        end
    end

    always_ff @(posedge Clock or negedge Resetn) begin
        if (!Resetn) begin
            fullValid <= 1'b0;
        end else if (advance) begin
            fullValid <= winValid;
        end
    end

    always_ff @(posedge Clock) begin
        if (advance && winValid) begin
            fullData.yEven <= winData.yEven;
            fullData.yOdd  <= winData.yOdd;
            fullData.uEven <= winData.uTaps[centreTap];
            fullData.vEven <= winData.vTaps[centreTap];
            // Overshoot near sharp edges can leave 0 to 255
            fullData.uOdd  <= clipPixel(accU >>> filterShift);
            fullData.vOdd  <= clipPixel(accV >>> filterShift);
        end
    end

endmodule

//--- verilog/rgbConverter.sv
// Two-stage fixed-point colour matrix for one pixel pair
// Stage one forms the products, stage two sums, scales and clips
`timescale 1ns/1ps

module rgbConverter (
    input  logic            Clock,
    input  logic            Resetn,
    input  logic            fullValid,
    input  yuvPkg::yuvFullT fullData,
    output logic            fullReady,
    output logic            outValid,
    output yuvPkg::rgbPairT outPair,
    input  logic            outReady
);
    import yuvPkg::*;

    // Matrix products of one pixel
    typedef struct packed {
        logic signed [31:0] luma;
        logic signed [31:0] red;
        logic signed [31:0] greenU;
        logic signed [31:0] greenV;
        logic signed [31:0] blue;
    } termsT;

    termsT evenTerms;
    termsT oddTerms;
    logic  midValid;
    logic  productAdvance;
    logic  sumAdvance;

    function automatic termsT matrixTerms(input logic [pixelWidth-1:0] y,
                                          input logic [pixelWidth-1:0] u,
                                          input logic [pixelWidth-1:0] v);
        int    yOff;
        int    uOff;
        int    vOff;
        termsT terms;
        // Offsets kept signed so dark luma goes below zero
        yOff = int'(y) - lumaOffset;
        uOff = int'(u) - chromaOffset;
        vOff = int'(v) - chromaOffset;
        terms.luma   = lumaGain * yOff;
        terms.red    = rFromV * vOff;
        terms.greenU = gFromU * uOff;
        terms.greenV = gFromV * vOff;
        terms.blue   = bFromU * uOff;
        return terms;
    endfunction

    function automatic logic [pixelWidth-1:0] scaleClip(input int sum);
        return clipPixel((sum + matrixRound) >>> matrixShift);
    endfunction

    always_comb begin
        sumAdvance     = !outValid || outReady;
        productAdvance = !midValid || sumAdvance;
        fullReady      = productAdvance;
    end

    always_ff @(posedge Clock or negedge Resetn) begin
        if (!Resetn) begin
            midValid <= 1'b0;
            outValid <= 1'b0;
        end else begin
            if (productAdvance) begin
                midValid <= fullValid;
            end
            if (sumAdvance) begin
                outValid <= midValid;
            end
        end
    end

    always_ff @(posedge Clock) begin
        if (productAdvance && fullValid) begin
            evenTerms <= matrixTerms(fullData.yEven, fullData.uEven, fullData.vEven);
            oddTerms  <= matrixTerms(fullData.yOdd, fullData.uOdd, fullData.vOdd);
        end
        if (sumAdvance && midValid) begin
            outPair.rEven <= scaleClip(evenTerms.luma + evenTerms.red);
            outPair.gEven <= scaleClip(evenTerms.luma - evenTerms.greenU - evenTerms.greenV);
            outPair.bEven <= scaleClip(evenTerms.luma + evenTerms.blue);
            outPair.rOdd  <= scaleClip(oddTerms.luma + oddTerms.red);
            outPair.gOdd  <= scaleClip(oddTerms.luma - oddTerms.greenU - oddTerms.greenV);
            outPair.bOdd  <= scaleClip(oddTerms.luma + oddTerms.blue);
        end
    end

endmodule

//--- verilog/yuvToRgb.sv
// Top level of the YUV 4:2:2 to RGB stream converter
// Chains the chroma window, the interpolation filter and the colour matrix
`timescale 1ns/1ps

module yuvToRgb #(
    parameter int LineWidth = 160
) (
    input  logic            Clock,
    input  logic            Resetn,
    input  logic            inValid,
    input  yuvPkg::yuvPairT inPair,
    output logic            inReady,
    output logic            outValid,
    output yuvPkg::rgbPairT outPair,
    input  logic            outReady
);
    import yuvPkg::*;

    logic    winValid;
    logic    winReady;
    windowT  winData;
    logic    fullValid;
    logic    fullReady;
    yuvFullT fullData;

    chromaWindow #(
        .LineWidth(LineWidth)
    ) window (
        .Clock, .Resetn,
        .inValid, .inPair, .inReady,
        .winValid, .winData, .winReady
    );

    chromaFilter filter (
        .Clock, .Resetn,
        .winValid, .winData, .winReady,
        .fullValid, .fullData, .fullReady
    );

    rgbConverter converter (
        .Clock, .Resetn,
        .fullValid, .fullData, .fullReady,
        .outValid, .outPair, .outReady
    );

endmodule

//--- dv/yuvToRgb_assertions.sv
// Concurrent checks bound into the converter top level
// Hold of stalled output beats, output count against accepted input
// Input blocked for the five drain steps after each line
`timescale 1ns/1ps

module yuvToRgbAssertions #(
    parameter int LineWidth = 160
) (
    input logic                Clock,
    input logic                Resetn,
    input logic                inValid,
    input logic                inReady,
    input logic                outValid,
    input yuvPkg::rgbPairT     outPair,
    input logic                outReady,
    input yuvPkg::windowStateT windowState
);
    import yuvPkg::*;

    // Outputs that follow the last input of a line
    localparam int drainSteps = 5;

    int   failCount = 0;
    int   acceptedCount;
    int   deliveredCount;
    int   linePos;
    int   drainLeft;
    logic lineEnd;

    always_comb begin
        lineEnd = inValid && inReady && (linePos == LineWidth - 1);
    end

    // Input and output beats counted at the top level ports
    always_ff @(posedge Clock or negedge Resetn) begin
        if (!Resetn) begin
            acceptedCount  <= 0;
            deliveredCount <= 0;
            linePos        <= 0;
            drainLeft      <= 0;
        end else begin
            if (inValid && inReady) begin
                acceptedCount <= acceptedCount + 1;
                linePos       <= lineEnd ? 0 : linePos + 1;
            end
            if (outValid && outReady) begin
                deliveredCount <= deliveredCount + 1;
            end
            if (lineEnd) begin
                drainLeft <= drainSteps;
            end else if (drainLeft != 0) begin
                drainLeft <= drainLeft - 1;
            end
        end
    end

    outputHeld: assert property (@(posedge Clock) disable iff (!Resetn)
        outValid && !outReady |=> outValid && $stable(outPair))
    else begin
        $error("outValid or outPair changed while the output was stalled");
        failCount++;
    end

    // Each output pair needs an input pair taken with inReady high
    outputHasInput: assert property (@(posedge Clock) disable iff (!Resetn)
        outValid |-> deliveredCount < acceptedCount)
    else begin
        $error("output pair presented without a matching accepted input pair");
        failCount++;
    end

    drainBlocksInput: assert property (@(posedge Clock) disable iff (!Resetn)
        drainLeft != 0 |-> windowState == winDrain && !inReady)
    else begin
        $error("inReady was high within five cycles of the last input of a line");
        failCount++;
    end

endmodule

bind yuvToRgb yuvToRgbAssertions #(
    .LineWidth(LineWidth)
) checks (.*, .windowState(window.state));

//--- dv/yuvToRgbTb.sv
// Testbench for the YUV 4:2:2 to RGB converter
// Line stimulus, reference model of window, filter and matrix, output monitor
`timescale 1ns/1ps

module yuvToRgbTb;
    import yuvPkg::*;

    localparam int lineWidth = 8;
    localparam int waitLimit = 400;

    logic    Clock = 1'b0;
    logic    Resetn;
    logic    inValid;
    yuvPairT inPair;
    logic    inReady;
    logic    outValid;
    rgbPairT outPair;
    logic    outReady = 1'b1;

    bit      randomReady;
    yuvPairT lineBuf [lineWidth];
    rgbPairT expected [$];
    rgbPairT want;
    int      errorCount;
    int      pairCount;
    int      testCount;
    int      failedTests;
    int      testStartErrors;
    int      testStartPairs;

    yuvToRgb #(
        .LineWidth(lineWidth)
    ) dut (
        .Clock, .Resetn,
        .inValid, .inPair, .inReady,
        .outValid, .outPair, .outReady
    );

    always #50 Clock = ~Clock;

    always @(posedge Clock) begin
        #1;
        outReady = randomReady ? ($urandom % 2 == 0) : 1'b1;
    end

    function automatic logic [7:0] clampByte(input int value);
        return (value < 0) ? 8'd0 : (value > 255) ? 8'd255 : 8'(value);
    endfunction

    // Sample index with the first and last pair of the line replicated
    function automatic int edgeIndex(input int i);
        return (i < 0) ? 0 : (i >= lineWidth) ? lineWidth - 1 : i;
    endfunction

    // Odd chroma halfway between pair k and pair k+1
    function automatic logic [7:0] oddChroma(input int k, input bit useV);
        int      acc;
        yuvPairT sample;
        acc = filterRound;
        for (int i = 0; i < filterLength; i++) begin
            sample = lineBuf[edgeIndex(k + i - centreTap)];
            acc += filterTaps[i] * int'(useV ? sample.v : sample.u);
        end
        return clampByte(acc >>> filterShift);
    endfunction

    function automatic logic [23:0] pixelRgb(input logic [7:0] y, input logic [7:0] u,
                                             input logic [7:0] v);
        int luma;
        int uOff;
        int vOff;
        luma = lumaGain * (int'(y) - lumaOffset);
        uOff = int'(u) - chromaOffset;
        vOff = int'(v) - chromaOffset;
        return {clampByte((luma + rFromV * vOff + matrixRound) >>> matrixShift),
                clampByte((luma - gFromU * uOff - gFromV * vOff + matrixRound) >>> matrixShift),
                clampByte((luma + bFromU * uOff + matrixRound) >>> matrixShift)};
    endfunction

    function automatic int totalErrors();
        return errorCount + dut.checks.failCount;
    endfunction

    task automatic modelLine();
        rgbPairT result;
        for (int k = 0; k < lineWidth; k++) begin
            {result.rEven, result.gEven, result.bEven} =
                pixelRgb(lineBuf[k].yEven, lineBuf[k].u, lineBuf[k].v);
            {result.rOdd, result.gOdd, result.bOdd} =
                pixelRgb(lineBuf[k].yOdd, oddChroma(k, 1'b0), oddChroma(k, 1'b1));
            expected.push_back(result);
        end
    endtask

    task automatic fillRandom();
        for (int k = 0; k < lineWidth; k++) begin
            lineBuf[k] = $urandom;
        end
    endtask

    // Holds the pair until the edge where inReady was high
    task automatic sendPair(input yuvPairT pair);
        int waited;
        bit taken;
        waited = 0;
        taken = 1'b0;
        inValid = 1'b1;
        inPair = pair;
        while (!taken) begin
            @(negedge Clock);
            taken = inReady;
            @(posedge Clock);
            #1;
            waited++;
            if (!taken && waited > waitLimit) begin
                abortRun("input pair was never accepted");
            end
        end
        inValid = 1'b0;
    endtask

    task automatic sendLine(input bit gaps);
        modelLine();
        for (int k = 0; k < lineWidth; k++) begin
            if (gaps) begin
                repeat ($urandom % 3) begin
                    @(posedge Clock);
                    #1;
                end
            end
            sendPair(lineBuf[k]);
        end
    endtask

    task automatic waitForOutputs();
        int waited;
        waited = 0;
        while (expected.size() != 0) begin
            @(posedge Clock);
            #1;
            waited++;
            if (waited > waitLimit) begin
                abortRun("expected output pairs did not arrive");
            end
        end
    endtask

    task automatic checkIdle();
        @(negedge Clock);
        assert (!outValid) else begin
            $display("FAILED at %0t: outValid = %b, expected 0", $time, outValid);
            errorCount++;
        end
        @(posedge Clock);
        #1;
    endtask

    task automatic beginTest();
        testCount++;
        testStartErrors = totalErrors();
        testStartPairs = pairCount;
    endtask

    task automatic endTest(input string name, input int lines);
        int pairs;
        int errors;
        pairs = pairCount - testStartPairs;
        assert (pairs == lines * lineWidth) else begin
            $display("FAILED at %0t: output pair count = %0d, expected %0d",
                     $time, pairs, lines * lineWidth);
            errorCount++;
        end
        errors = totalErrors() - testStartErrors;
        if (errors != 0) begin
            failedTests++;
        end
        $display("Test %0d %s: %s, %0d pairs, %0d errors", testCount, name,
                 (errors == 0) ? "ok" : "failed", pairs, errors);
    endtask

    task automatic finishRun();
        $display("%0d tests, %0d failed, %0d pairs checked, %0d errors",
                 testCount, failedTests, pairCount, totalErrors());
        if (totalErrors() == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    endtask

    task automatic abortRun(input string reason);
        $display("Timeout at %0t: %s", $time, reason);
        errorCount++;
        finishRun();
    endtask

    // A transfer happens at the next rising edge
    always @(negedge Clock) begin
        if (Resetn && outValid && outReady) begin
            if (expected.size() == 0) begin
                $display("Output pair at %0t arrived with none expected", $time);
                errorCount++;
            end else begin
                want = expected.pop_front();
                pairCount++;
                assert (outPair == want) else begin
                    $display("FAILED at %0t: outPair = %h, expected %h", $time, outPair, want);
                    errorCount++;
                end
            end
        end
    end

    initial begin
        void'($urandom(32'hc13a35eb));
        Resetn = 1'b0;
        inValid = 1'b0;
        inPair = '0;
        randomReady = 1'b0;
        errorCount = 0;
        pairCount = 0;
        testCount = 0;
        failedTests = 0;
        repeat (16) @(posedge Clock);
        #1;
        Resetn = 1'b1;

        // Nothing leaves the window before the sixth pair of a line
        beginTest();
        checkIdle();
        fillRandom();
        modelLine();
        for (int k = 0; k < lineWidth; k++) begin
            if (k == 5) begin
                repeat (12) checkIdle();
            end
            sendPair(lineBuf[k]);
        end
        waitForOutputs();
        endTest("no output before sixth pair", 1);

        beginTest();
        for (int k = 0; k < lineWidth; k++) begin
            lineBuf[k] = (k % 2 == 0) ? {8'd16, 8'd235, 8'd128, 8'd128}
                                      : {8'd235, 8'd16, 8'd128, 8'd128};
        end
        sendLine(1'b0);
        waitForOutputs();
        endTest("black and white levels", 1);

        // Alternating chroma extremes push both clip directions
        beginTest();
        for (int k = 0; k < lineWidth; k++) begin
            lineBuf[k] = (k % 2 == 0) ? {8'($urandom), 8'($urandom), 8'd0, 8'd255}
                                      : {8'($urandom), 8'($urandom), 8'd255, 8'd0};
        end
        sendLine(1'b0);
        waitForOutputs();
        endTest("extreme chroma", 1);

        beginTest();
        fillRandom();
        for (int k = 0; k < lineWidth; k++) begin
            lineBuf[k].u = 8'(k * 32);
        end
        sendLine(1'b0);
        fillRandom();
        for (int k = 0; k < lineWidth; k++) begin
            lineBuf[k].v = 8'(255 - k * 32);
        end
        sendLine(1'b0);
        waitForOutputs();
        endTest("ramp and random chroma over two lines", 2);

        beginTest();
        randomReady = 1'b1;
        repeat (3) begin
            fillRandom();
            sendLine(1'b1);
        end
        waitForOutputs();
        randomReady = 1'b0;
        endTest("random stalls and input gaps", 3);

        finishRun();
    end

endmodule

//--- project.f
verilog/yuvPkg.sv
verilog/chromaWindow.sv
verilog/chromaFilter.sv
verilog/rgbConverter.sv
verilog/yuvToRgb.sv
dv/yuvToRgb_assertions.sv
dv/yuvToRgbTb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the yuvToRgb testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module yuvToRgbTb \
    -f project.f \
    -o yuvToRgbSim

# An assertion error may end the run with a nonzero status, the log decides
./obj_dir/yuvToRgbSim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1
